//--- run_sim.sh
#!/bin/sh
# build and run the ALU coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_alu_core

status=0
out="$(./obj_dir/Vtb_alu_core 2>&1)" || status=$?
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
else
  echo "simulation exit status $status"
  exit 1
fi

//--- tb.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/cl_add_sub.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/wb_alu_slave.sv
verilog/alu_core_top.sv
test/tb_alu_core.sv

//--- test/tb_alu_core.sv
/*
  random and directed test of the ALU coprocessor over its wishbone port
  results are compared with a model of the register file and flags
  one bus access at a time, driven 1 ns after the rising edge
*/
`timescale 1ns/1ns
`include "alu_config.svh"

module tb_alu_core;
  import alu_pkg::*;

  localparam int NumRandom  = 300;
  localparam int NumCorner  = 6;
  // reset reads, random and corner instrs with two reads each, ignored writes and reads
  localparam int NumTxn     = 5 + 3 * NumRandom + 3 * NumCorner + 7 + 5 + 3;
  localparam int TimeoutCyc = 20 * NumTxn + 100;

  logic    clk;
  logic    rst_n;
  wb_req_t req;
  wb_rsp_t rsp;
  int      cycle_count;

  // model state
  logic [`ALU_BW-1:0] model_regs [`ALU_NREGS];
  alu_flags_t         model_flags;

  alu_core_top dut0 (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .wb_req_i(req),
    .wb_rsp_o(rsp)
  );

  always #4 clk = ~clk;

  // --------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_reg(input logic [`ALU_BW-1:0] got, input logic [`ALU_BW-1:0] exp,
                           input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %02h expected %02h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_flags(input alu_flags_t got, input alu_flags_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s flags vnz got %03b expected %03b",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_word(input logic [`WB_DW-1:0] got, input logic [`WB_DW-1:0] exp,
                            input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %04h expected %04h",
                                  $time, what, got, exp));
    end
  endtask

  // --------------------------------------------------
  // bus access, entered and left 1 ns after an edge
  // --------------------------------------------------
  task automatic bus_access(input logic we, input logic [`WB_AW-1:0] adr,
                            input logic [`WB_DW-1:0] dat, output logic [`WB_DW-1:0] rdat);
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    @(posedge clk);
    #1;
    // ack must follow the strobe by exactly one edge
    if (rsp.ack !== 1'b1) begin
      stop_with_failure($sformatf("ack did not rise one cycle after strobe, address %0d", adr));
    end
    rdat = rsp.dat;
    // strobe still up at the next edge, the slave must not ack it again
    @(posedge clk);
    #1;
    req = '0;
    if (rsp.ack !== 1'b0) begin
      stop_with_failure($sformatf("ack stayed high a second cycle, address %0d", adr));
    end
  endtask

  task automatic read_reg(input reg_idx_t idx, output logic [`ALU_BW-1:0] val);
    logic [`WB_DW-1:0] word;
    bus_access(1'b0, `WB_AW'(idx), '0, word);
    // upper bits are zero extension
    check_word(word & ~`WB_DW'({`ALU_BW{1'b1}}), '0, "register read upper bits");
    val = word[`ALU_BW-1:0];
  endtask

  task automatic read_flags(output alu_flags_t f);
    logic [`WB_DW-1:0] word;
    bus_access(1'b0, `WB_AW'(4), '0, word);
    check_word(word & ~`WB_DW'(3'b111), '0, "flags read upper bits");
    f = word[2:0];
  endtask

  // --------------------------------------------------
  // model of one instruction
  // --------------------------------------------------
  task automatic model_exec(input alu_instr_u ins);
    logic [`ALU_BW-1:0] a;
    logic [`ALU_BW-1:0] b;
    logic [`ALU_BW-1:0] res;
    int                 wide;
    a = model_regs[ins.r.ra];
    // fmt picks immediate or register rb
    b = ins.r.fmt ? ins.i.imm : model_regs[ins.r.rb];
    model_flags.v = 1'b0;
    case (ins.r.op)
      OP_ADD: begin
        wide = int'($signed(a)) + int'($signed(b));
        res  = wide[`ALU_BW-1:0];
        model_flags.v = (wide > 127) || (wide < -128);
      end
      OP_SUB: begin
        wide = int'($signed(a)) - int'($signed(b));
        res  = wide[`ALU_BW-1:0];
        model_flags.v = (wide > 127) || (wide < -128);
      end
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_INC:  res = a + `ALU_BW'(1);
      OP_MOVA: res = a;
      default: res = b;
    endcase
    model_flags.n = res[`ALU_BW-1];
    model_flags.z = (res == '0);
    model_regs[ins.r.rd] = res;
  endtask

  // issue, then read back rd and flags
  task automatic run_instr(input alu_instr_u ins);
    logic [`WB_DW-1:0]  unused;
    logic [`ALU_BW-1:0] got;
    alu_flags_t         got_f;
    bus_access(1'b1, '0, ins, unused);
    model_exec(ins);
    read_reg(ins.r.rd, got);
    check_reg(got, model_regs[ins.r.rd], $sformatf("instr %04h rd r%0d", ins, ins.r.rd));
    read_flags(got_f);
    check_flags(got_f, model_flags, $sformatf("instr %04h", ins));
  endtask

  function automatic alu_instr_u make_imm(input alu_op_e op, input reg_idx_t rd,
                                          input reg_idx_t ra, input logic [7:0] imm);
    alu_instr_u ins;
    ins.i.op  = op;
    ins.i.fmt = 1'b1;
    ins.i.rd  = rd;
    ins.i.ra  = ra;
    ins.i.imm = imm;
    return ins;
  endfunction

  function automatic alu_instr_u make_reg(input alu_op_e op, input reg_idx_t rd,
                                          input reg_idx_t ra, input reg_idx_t rb);
    alu_instr_u ins;
    ins.r.op  = op;
    ins.r.fmt = 1'b0;
    ins.r.rd  = rd;
    ins.r.ra  = ra;
    ins.r.rb  = rb;
    ins.r.pad = '0;
    return ins;
  endfunction

  // run length guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCyc) begin
      stop_with_failure("simulation timed out without finishing");
    end
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int unsigned        seed_val;
    logic [`ALU_BW-1:0] got;
    logic [`WB_DW-1:0]  word;
    alu_flags_t         got_f;
    seed_val    = $urandom(32'h27e6d694);
    clk         = 1'b0;
    rst_n       = 1'b0;
    req         = '0;
    cycle_count = 0;
    model_flags = '0;
    for (int i = 0; i < `ALU_NREGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset values
    for (int i = 0; i < `ALU_NREGS; i++) begin
      read_reg(reg_idx_t'(i), got);
      check_reg(got, '0, $sformatf("reset r%0d", i));
    end
    read_flags(got_f);
    check_flags(got_f, '0, "reset");

    // random words exercise both instruction views
    for (int n = 0; n < NumRandom; n++) begin
      run_instr(alu_instr_u'(`WB_DW'($urandom)));
    end

    // add/sub corners: 127+1, -128-1, 0-0
    run_instr(make_imm(OP_MOVB, 2'd0, 2'd0, 8'd127));
    run_instr(make_imm(OP_ADD, 2'd1, 2'd0, 8'd1));
    run_instr(make_imm(OP_MOVB, 2'd2, 2'd0, 8'h80));
    run_instr(make_imm(OP_SUB, 2'd3, 2'd2, 8'd1));
    run_instr(make_imm(OP_MOVB, 2'd0, 2'd0, 8'd0));
    run_instr(make_reg(OP_SUB, 2'd1, 2'd0, 2'd0));

    // writes off address 0 change nothing
    for (int adr = 1; adr < 8; adr++) begin
      bus_access(1'b1, `WB_AW'(adr), `WB_DW'($urandom), word);
    end
    for (int i = 0; i < `ALU_NREGS; i++) begin
      read_reg(reg_idx_t'(i), got);
      check_reg(got, model_regs[i], $sformatf("after ignored writes r%0d", i));
    end
    read_flags(got_f);
    check_flags(got_f, model_flags, "after ignored writes");
    for (int adr = 5; adr < 8; adr++) begin
      bus_access(1'b0, `WB_AW'(adr), '0, word);
      check_word(word, '0, $sformatf("unmapped read address %0d", adr));
    end

    $display("Verification passed");
    $finish;
  end

endmodule

//--- verilog/alu.sv
/*
  signed ALU, eight operations, purely combinational
  v is only raised for add and sub; n and z follow every result
  carry out of the adders is not brought out
*/
`timescale 1ns/1ns
`include "alu_config.svh"

module alu #(
  parameter int BW = `ALU_BW
) (
  input  logic signed [BW-1:0] a_i,
  input  logic signed [BW-1:0] b_i,
  input  alu_pkg::alu_op_e     op_i,
  output logic [BW-1:0]        result_o,
  output alu_pkg::alu_flags_t  flags_o
);
  import alu_pkg::*;

  logic [BW-1:0] add_sub_res;
  logic [BW-1:0] inc_res;
  logic          ovf;
  logic [BW:0]   wide_res;

  // ------------------------------------------------
  // arithmetic units
  // ------------------------------------------------

  // add/sub share one adder, op bit 0 picks subtract
  cl_add_sub #(
    .Width(BW)
  ) u_add_sub (
    .a_i  (a_i),
    .b_i  (b_i),
    .sub_i(op_i[0]),
    .sum_o(add_sub_res),
    .c_o  ()
  );

  // increment of a
  cl_add_sub #(
    .Width(BW)
  ) u_inc (
    .a_i  (a_i),
    .b_i  (BW'(1)),
    .sub_i(1'b0),
    .sum_o(inc_res),
    .c_o  ()
  );

  // ------------------------------------------------
  // result select
  // ------------------------------------------------
  always_comb begin
    case (op_i)
      OP_ADD,
      OP_SUB:  result_o = add_sub_res;
      OP_AND:  result_o = a_i & b_i;
      OP_OR:   result_o = a_i | b_i;
      OP_XOR:  result_o = a_i ^ b_i;
      OP_INC:  result_o = inc_res;
      OP_MOVA: result_o = a_i;
      OP_MOVB: result_o = b_i;
      default: result_o = '0;
    endcase
  end

  // signed overflow
  always_comb begin
    ovf = 1'b0;
    if (op_i == OP_ADD) begin
      // like signs in, other sign out
      ovf = (a_i[BW-1] == b_i[BW-1]) && (a_i[BW-1] != add_sub_res[BW-1]);
    end else if (op_i == OP_SUB) begin
      // unlike signs in, sign of a lost
      ovf = (a_i[BW-1] != b_i[BW-1]) && (a_i[BW-1] != add_sub_res[BW-1]);
    end
  end

  assign flags_o.v = ovf;
  assign flags_o.n = result_o[BW-1];
  assign flags_o.z = (result_o == '0);

  // sign extended by one bit, top two bits differ on overflow
  always_comb begin
    if (op_i == OP_SUB) begin
      wide_res = {a_i[BW-1], a_i} - {b_i[BW-1], b_i};
    end else begin
      wide_res = {a_i[BW-1], a_i} + {b_i[BW-1], b_i};
    end
  end

  // v matches the widened sum for add and sub, and stays low for every other op
  always_comb begin
    assert (flags_o.v == ((op_i == OP_ADD || op_i == OP_SUB)
                          && (wide_res[BW] != wide_res[BW-1])))
      else $error("alu: overflow flag wrong for op %0d", op_i);
  end

endmodule

//--- verilog/alu_config.svh
/*
  width settings for the ALU coprocessor
  WB_DW must hold one full instruction word (16 bits)
  ALU_NREGS must be a power of two, since the register index is log2 wide
*/
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// alu datapath width
`define ALU_BW    8
// general purpose registers
`define ALU_NREGS 4
// wishbone data and word address widths
`define WB_DW     16
`define WB_AW     3

`endif

//--- verilog/alu_core_top.sv
/*
  ALU coprocessor top, wishbone classic slave port only
  one bus access per instruction, results land with ack
*/
`timescale 1ns/1ns
`include "alu_config.svh"

module alu_core_top (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  alu_pkg::wb_req_t wb_req_i,
  output alu_pkg::wb_rsp_t wb_rsp_o
);
  import alu_pkg::*;

  // register file ports
  reg_idx_t           ra;
  reg_idx_t           rb;
  reg_idx_t           wa;
  logic               we;
  logic [`ALU_BW-1:0] rda;
  logic [`ALU_BW-1:0] rdb;
  logic [`ALU_BW-1:0] wd;
  // alu ports
  alu_op_e            op;
  logic [`ALU_BW-1:0] opb;
  logic [`ALU_BW-1:0] result;
  alu_flags_t         flags;

  // ------------------------------------------------
  // bus slave and decode
  // ------------------------------------------------
  wb_alu_slave u_slave (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wb_req_i(wb_req_i),
    .wb_rsp_o(wb_rsp_o),
    .ra_o    (ra),
    .rb_o    (rb),
    .rda_i   (rda),
    .rdb_i   (rdb),
    .op_o    (op),
    .opb_o   (opb),
    .result_i(result),
    .flags_i (flags),
    .we_o    (we),
    .wa_o    (wa),
    .wd_o    (wd)
  );

  // registers
  reg_file #(
    .BW(`ALU_BW)
  ) u_regs (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .ra_i   (ra),
    .rb_i   (rb),
    .we_i   (we),
    .wa_i   (wa),
    .wd_i   (wd),
    .rda_o  (rda),
    .rdb_o  (rdb)
  );

  // datapath, operand a always from port a
  alu #(
    .BW(`ALU_BW)
  ) u_alu (
    .a_i     (rda),
    .b_i     (opb),
    .op_i    (op),
    .result_o(result),
    .flags_o (flags)
  );

endmodule

//--- verilog/alu_pkg.sv
/*
  shared types for the ALU coprocessor
  instruction layout is fixed at 16 bits and 8-bit immediates
  op, fmt, rd and ra sit at the same bits in both instruction views
*/
`include "alu_config.svh"

package alu_pkg;

  // register index
  typedef logic [$clog2(`ALU_NREGS)-1:0] reg_idx_t;

  // opcodes, same order as the alu result mux
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_INC  = 3'd5,
    OP_MOVA = 3'd6,
    OP_MOVB = 3'd7
  } alu_op_e;

  // status flags, read back as {v, n, z}
  typedef struct packed {
    logic v;
    logic n;
    logic z;
  } alu_flags_t;

  // ------------------------------------------------
  // instruction word
  // ------------------------------------------------

  // register-register, fmt = 0
  typedef struct packed {
    alu_op_e    op;
    logic       fmt;
    reg_idx_t   rd;
    reg_idx_t   ra;
    reg_idx_t   rb;
    logic [5:0] pad;
  } alu_instr_r_t;

  // register-immediate, fmt = 1
  typedef struct packed {
    alu_op_e           op;
    logic              fmt;
    reg_idx_t          rd;
    reg_idx_t          ra;
    logic [`ALU_BW-1:0] imm;
  } alu_instr_i_t;

  typedef union packed {
    alu_instr_r_t r;
    alu_instr_i_t i;
  } alu_instr_u;

  // ------------------------------------------------
  // wishbone classic, master to slave and back
  // ------------------------------------------------
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [`WB_AW-1:0] adr;
    logic [`WB_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic [`WB_DW-1:0] dat;
  } wb_rsp_t;

endpackage

//--- verilog/cl_add_sub.sv
/*
  carry-lookahead adder/subtractor, fully combinational
  lookahead inside 4-bit groups, group carries ripple between groups
  Width need not be a multiple of 4; the top group is zero padded
*/
`timescale 1ns/1ns

module cl_add_sub #(
  parameter int Width = 8
) (
  input  logic [Width-1:0] a_i,
  input  logic [Width-1:0] b_i,
  input  logic             sub_i,
  output logic [Width-1:0] sum_o,
  output logic             c_o
);

  localparam int NGroups = (Width + 3) / 4;
  localparam int PadW    = NGroups * 4;

  // padded operands, b inverted for subtraction
  logic [PadW-1:0] a_pad;
  logic [PadW-1:0] b_pad;
  logic [PadW-1:0] g;
  logic [PadW-1:0] p;
  logic [PadW:0]   c;
  logic [PadW-1:0] sum_pad;

  assign a_pad = PadW'(a_i);
  assign b_pad = PadW'(b_i ^ {Width{sub_i}});
  assign g     = a_pad & b_pad;
  assign p     = a_pad ^ b_pad;

  // two's complement: a + ~b + 1
  assign c[0] = sub_i;

  for (genvar gi = 0; gi < NGroups; gi++) begin : g_group
    localparam int B = gi * 4;

    // in-group carries straight from group carry-in
    assign c[B+1] = g[B] | (p[B] & c[B]);
    assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & c[B]);
    assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B])
                  | (p[B+2] & p[B+1] & p[B] & c[B]);
    // group generate/propagate drive the carry into the next group
    assign c[B+4] = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1])
                  | (p[B+3] & p[B+2] & p[B+1] & g[B])
                  | (p[B+3] & p[B+2] & p[B+1] & p[B] & c[B]);
  end

  assign sum_pad = p ^ c[PadW-1:0];
  assign sum_o   = sum_pad[Width-1:0];
  // padding bits are zero, so carry at Width is the true carry out
  assign c_o     = c[Width];

endmodule

//--- verilog/reg_file.sv
/*
  general purpose register file
  one write port, written on the clock edge
  two combinational read ports, no write-to-read bypass
*/
`timescale 1ns/1ns
`include "alu_config.svh"

module reg_file #(
  parameter int BW = `ALU_BW
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  alu_pkg::reg_idx_t ra_i,
  input  alu_pkg::reg_idx_t rb_i,
  input  logic              we_i,
  input  alu_pkg::reg_idx_t wa_i,
  input  logic [BW-1:0]     wd_i,
  output logic [BW-1:0]     rda_o,
  output logic [BW-1:0]     rdb_o
);

  logic [BW-1:0] regs_q [`ALU_NREGS];

  // ------------------------------------------------
  // write port
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // all registers read 0 after reset
      for (int i = 0; i < `ALU_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[wa_i] <= wd_i;
    end
  end

  // read ports
  // old value seen during the write cycle
  assign rda_o = regs_q[ra_i];
  assign rdb_o = regs_q[rb_i];

endmodule

//--- verilog/wb_alu_slave.sv
/*
  wishbone classic slave for the ALU coprocessor
  single-cycle ack, no block cycles, no err/rty, no byte selects
  write to word 0 issues an instruction; other writes are acked and dropped
  reads: words 0..3 registers, word 4 flags, 5..7 read 0
*/
`timescale 1ns/1ns
`include "alu_config.svh"

module wb_alu_slave (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  alu_pkg::wb_req_t    wb_req_i,
  output alu_pkg::wb_rsp_t    wb_rsp_o,
  output alu_pkg::reg_idx_t   ra_o,
  output alu_pkg::reg_idx_t   rb_o,
  input  logic [`ALU_BW-1:0]  rda_i,
  input  logic [`ALU_BW-1:0]  rdb_i,
  output alu_pkg::alu_op_e    op_o,
  output logic [`ALU_BW-1:0]  opb_o,
  input  logic [`ALU_BW-1:0]  result_i,
  input  alu_pkg::alu_flags_t flags_i,
  output logic                we_o,
  output alu_pkg::reg_idx_t   wa_o,
  output logic [`ALU_BW-1:0]  wd_o
);
  import alu_pkg::*;

  localparam logic [`WB_AW-1:0] AdrInstr = `WB_AW'(0);
  localparam logic [`WB_AW-1:0] AdrFlags = `WB_AW'(4);

  alu_instr_u        instr;
  logic              access;
  logic              issue;
  logic              ack_q;
  logic [`WB_DW-1:0] rdat_d;
  logic [`WB_DW-1:0] rdat_q;
  alu_flags_t        flags_q;

  // ------------------------------------------------
  // bus handshake
  // ------------------------------------------------

  // new strobe seen, blocked while ack is out
  assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  // instruction write, commits on the acking edge
  assign issue  = access && wb_req_i.we && (wb_req_i.adr == AdrInstr);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // ------------------------------------------------
  // instruction decode and operand routing
  // ------------------------------------------------
  assign instr = wb_req_i.dat;

  // reads borrow port a to fetch the addressed register
  assign ra_o  = wb_req_i.we ? instr.r.ra : wb_req_i.adr[$bits(reg_idx_t)-1:0];
  assign rb_o  = instr.r.rb;
  assign op_o  = instr.r.op;
  // fmt picks imm or rb for operand b
  assign opb_o = instr.r.fmt ? instr.i.imm : rdb_i;

  // write-back, high for the one cycle before ack
  assign we_o = issue;
  assign wa_o = instr.r.rd;
  assign wd_o = result_i;

  // flags follow the last issued instruction
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      flags_q <= '0;
    end else if (issue) begin
      flags_q <= flags_i;
    end
  end

  // ------------------------------------------------
  // read data
  // ------------------------------------------------
  always_comb begin
    rdat_d = '0;
    if (wb_req_i.adr < `WB_AW'(`ALU_NREGS)) begin
      rdat_d = {{(`WB_DW - `ALU_BW){1'b0}}, rda_i};
    end else if (wb_req_i.adr == AdrFlags) begin
      rdat_d = {{(`WB_DW - $bits(alu_flags_t)){1'b0}}, flags_q};
    end
  end

  // registered with ack, held otherwise
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdat_q <= '0;
    end else if (access && !wb_req_i.we) begin
      rdat_q <= rdat_d;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdat_q;

  // ------------------------------------------------
  // protocol checks
  // ------------------------------------------------

  // one ack per strobe
  a_ack_single : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) ack_q |=> !ack_q
  ) else $error("wb_alu_slave: ack high two cycles in a row");

  // ack answers a strobe seen the cycle before
  a_ack_after_stb : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      ack_q |-> $past(wb_req_i.cyc && wb_req_i.stb)
  ) else $error("wb_alu_slave: ack without preceding cyc/stb");

endmodule
